// ==== rtl/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

	////////////////////
	// Field widths
	////////////////////
	localparam int XLEN      = 32;
	localparam int REG_IDX_W = 5;
	localparam int OPCODE_W  = 7;
	localparam int FUNCT3_W  = 3;
	localparam int FUNCT7_W  = 7;

	typedef logic [XLEN-1:0]      wordT;    // Data or address word
	typedef logic [REG_IDX_W-1:0] regIdxT;  // Register index
	typedef logic [FUNCT3_W-1:0]  funct3T;

	////////////////////
	// Major opcodes
	////////////////////
	typedef enum logic [OPCODE_W-1:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		SYSTEM = 7'b1110011
	} opcodeT;

	// The only SYSTEM encoding the core reacts to
	localparam wordT EBREAK_INSTR = 32'h0010_0073;

	localparam wordT RESET_PC = '0;  // First fetch address

endpackage

`default_nettype wire

// ==== rtl/rvPipePkg.sv ====
`default_nettype none

package rvPipePkg;

	// Execute-stage operation
	typedef enum logic [3:0] {
		ADD   = 4'd0,
		SUB   = 4'd1,
		SLL   = 4'd2,
		SLT   = 4'd3,
		SLTU  = 4'd4,
		XOR   = 4'd5,
		SRL   = 4'd6,
		SRA   = 4'd7,
		OR    = 4'd8,
		AND   = 4'd9,
		PASSB = 4'd10  // LUI passes the immediate through
	} aluOpT;

	// ALWAYS covers JAL and JALR
	typedef enum logic [2:0] {
		NONE, EQ, NE, LT, GE, LTU, GEU, ALWAYS
	} brCondT;

	typedef enum logic [1:0] {
		REGFILE = 2'd0,  // Value read in decode
		FROMMEM = 2'd1,  // EX/MEM result
		FROMWB  = 2'd2   // MEM/WB writeback data
	} fwdSelT;

	typedef enum logic [1:0] {
		ALU     = 2'd0,
		MEM     = 2'd1,
		PCPLUS4 = 2'd2   // Link value of JAL and JALR
	} wbSelT;

endpackage

`default_nettype wire

// ==== rtl/rvDecoder.sv ====
`default_nettype none
`timescale 1ns/100ps

module rvDecoder
	import rvIsaPkg::*, rvPipePkg::*;
(
	input  wire wordT instr,
	output regIdxT    rs1,
	output regIdxT    rs2,
	output regIdxT    rd,
	output wordT      imm,
	output aluOpT     aluOp,
	output brCondT    brCond,
	output wbSelT     wbSel,
	output logic      useImm,
	output logic      usePcA,
	output logic      regWrite,
	output logic      memRead,
	output logic      memWrite,
	output logic      isJalr,
	output logic      isHalt
);

	opcodeT               opcode;
	funct3T               funct3;
	logic [FUNCT7_W-1:0]  funct7;
	wordT                 immI, immS, immB, immU, immJ;
	logic                 writesRd;

	// SUB only exists in the register form, SRA/SRAI in both
	function automatic aluOpT aluFromFunct(funct3T f3, logic alt, logic isReg);
		aluOpT op;
		case (f3)
			3'b000:  op = (alt && isReg) ? SUB : ADD;
			3'b001:  op = SLL;
			3'b010:  op = SLT;
			3'b011:  op = SLTU;
			3'b100:  op = XOR;
			3'b101:  op = alt ? SRA : SRL;
			3'b110:  op = OR;
			default: op = AND;
		endcase
		return op;
	endfunction

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];

	////////////////////
	// Immediates
	////////////////////
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		imm      = '0;
		aluOp    = ADD;
		brCond   = NONE;
		wbSel    = ALU;
		useImm   = 1'b0;
		usePcA   = 1'b0;
		writesRd = 1'b0;
		memRead  = 1'b0;
		memWrite = 1'b0;
		isJalr   = 1'b0;
		isHalt   = 1'b0;
		case (opcode)
			OP: begin
				aluOp    = aluFromFunct(funct3, funct7[5], 1'b1);
				writesRd = 1'b1;
			end
			OP_IMM: begin
				aluOp    = aluFromFunct(funct3, funct7[5], 1'b0);
				imm      = immI;
				useImm   = 1'b1;
				writesRd = 1'b1;
			end
			LUI: begin
				aluOp    = PASSB;
				imm      = immU;
				useImm   = 1'b1;
				writesRd = 1'b1;
			end
			AUIPC: begin
				imm      = immU;
				useImm   = 1'b1;
				usePcA   = 1'b1;  // PC + upper immediate
				writesRd = 1'b1;
			end
			LOAD: begin
				imm      = immI;
				useImm   = 1'b1;
				wbSel    = MEM;
				memRead  = 1'b1;
				writesRd = 1'b1;
			end
			STORE: begin
				imm      = immS;
				useImm   = 1'b1;
				memWrite = 1'b1;
			end
			BRANCH: begin
				imm = immB;  // Operands stay rs1 and rs2 for the compare
				case (funct3)
					3'b000:  brCond = EQ;
					3'b001:  brCond = NE;
					3'b100:  brCond = LT;
					3'b101:  brCond = GE;
					3'b110:  brCond = LTU;
					3'b111:  brCond = GEU;
					default: brCond = NONE;
				endcase
			end
			JAL: begin
				imm      = immJ;
				brCond   = ALWAYS;
				wbSel    = PCPLUS4;
				writesRd = 1'b1;
			end
			JALR: begin
				imm      = immI;
				brCond   = ALWAYS;
				wbSel    = PCPLUS4;
				isJalr   = 1'b1;
				writesRd = 1'b1;
			end
			SYSTEM: isHalt = (instr == EBREAK_INSTR);
			default: ;  // Unknown opcode acts as a bubble
		endcase
	end

	assign regWrite = writesRd && (rd != '0);  // x0 is never written

endmodule

`default_nettype wire

// ==== rtl/rvAlu.sv ====
`default_nettype none
`timescale 1ns/100ps

module rvAlu
	import rvIsaPkg::*, rvPipePkg::*;
(
	input  wire aluOpT  aluOp,
	input  wire brCondT brCond,
	input  wire wordT   a,
	input  wire wordT   b,
	output wordT        result,
	output logic        taken
);

	logic [4:0] shamt;

	assign shamt = b[4:0];  // RV32I uses the low five bits only

	always_comb begin
		case (aluOp)
			ADD:     result = a + b;
			SUB:     result = a - b;
			SLL:     result = a << shamt;
			SLT:     result = {31'b0, $signed(a) < $signed(b)};
			SLTU:    result = {31'b0, a < b};
			XOR:     result = a ^ b;
			SRL:     result = a >> shamt;
			SRA:     result = wordT'($signed(a) >>> shamt);
			OR:      result = a | b;
			AND:     result = a & b;
			PASSB:   result = b;
			default: result = '0;
		endcase
	end

	////////////////////
	// Branch test
	////////////////////
	always_comb begin
		case (brCond)
			EQ:      taken = (a == b);
			NE:      taken = (a != b);
			LT:      taken = ($signed(a) < $signed(b));
			GE:      taken = ($signed(a) >= $signed(b));
			LTU:     taken = (a < b);
			GEU:     taken = (a >= b);
			ALWAYS:  taken = 1'b1;
			default: taken = 1'b0;  // NONE
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/rvHazardUnit.sv ====
`default_nettype none
`timescale 1ns/100ps

module rvHazardUnit
	import rvIsaPkg::*, rvPipePkg::*;
(
	input  wire regIdxT exRs1,
	input  wire regIdxT exRs2,
	input  wire regIdxT memRd,
	input  wire regIdxT wbRd,
	input  wire regIdxT exRd,
	input  wire logic   memRegWrite,
	input  wire logic   wbRegWrite,
	input  wire logic   exMemRead,
	input  wire logic   redirect,
	input  wire regIdxT idRs1,
	input  wire regIdxT idRs2,
	output fwdSelT      fwdA,
	output fwdSelT      fwdB,
	output logic        stall,
	output logic        flush
);

	logic loadHit;

	// Younger result in EX/MEM wins over MEM/WB
	function automatic fwdSelT pickFwd(
		regIdxT rs,
		regIdxT mRd,
		logic   mWe,
		regIdxT wRd,
		logic   wWe
	);
		fwdSelT sel;
		if (mWe && (mRd != '0) && (mRd == rs))
			sel = FROMMEM;
		else if (wWe && (wRd != '0) && (wRd == rs))
			sel = FROMWB;
		else
			sel = REGFILE;
		return sel;
	endfunction

	assign fwdA = pickFwd(exRs1, memRd, memRegWrite, wbRd, wbRegWrite);
	assign fwdB = pickFwd(exRs2, memRd, memRegWrite, wbRd, wbRegWrite);

	////////////////////
	// Load-use and redirect
	////////////////////
	// Load data is only ready in MEM/WB, so the consumer waits one cycle
	assign loadHit = (exRd != '0) && ((exRd == idRs1) || (exRd == idRs2));
	assign stall   = exMemRead && loadHit;

	assign flush = redirect;  // Drops the two wrong-path slots

endmodule

`default_nettype wire

// ==== rtl/rvTop.sv ====
`default_nettype none
`timescale 1ns/100ps

module rvTop
	import rvIsaPkg::*, rvPipePkg::*;
#(
	parameter int IMEM_ADDR_W = 12,
	parameter int DMEM_ADDR_W = 10
) (
	input  wire logic                    CLK,
	input  wire logic                    rstN,
	output logic [IMEM_ADDR_W-1:0]       iMemAddr,  // Byte address
	output logic                         iMemCsN,
	input  wire wordT                    iMemData,
	output logic                         dMemCsN,
	output logic                         dMemWeN,
	output logic [DMEM_ADDR_W-1:0]       dMemAddr,  // Word address
	output wordT                         dMemWdata,
	input  wire wordT                    dMemRdata,
	output regIdxT                       rfRa1,
	output regIdxT                       rfRa2,
	input  wire wordT                    rfRd1,
	input  wire wordT                    rfRd2,
	output logic                         rfWe,
	output regIdxT                       rfWa,
	output wordT                         rfWd,
	output logic                         halt,
	output logic [31:0]                  numInst
);

	wordT   pc, pcPlus4;
	logic   idValid;
	wordT   idInstr, idPc, idRs1Val, idRs2Val;
	regIdxT decRs1, decRs2, decRd;
	wordT   decImm;
	aluOpT  decAluOp;
	brCondT decBrCond;
	wbSelT  decWbSel;
	logic   decUseImm, decUsePcA, decRegWrite, decMemRead, decMemWrite, decIsJalr, decIsHalt;
	logic   exValid;
	wordT   exPc, exRs1Val, exRs2Val, exImm;
	regIdxT exRs1, exRs2, exRd;
	aluOpT  exAluOp;
	brCondT exBrCond;
	wbSelT  exWbSel;
	logic   exUseImm, exUsePcA, exRegWrite, exMemRead, exMemWrite, exIsJalr, exIsHalt;
	fwdSelT fwdA, fwdB;
	wordT   fwdValA, fwdValB, aluA, aluB, aluResult, targetSum, target;
	logic   taken, redirect, stall, flush;
	logic   memValid;
	wordT   memAlu, memPc4, memStoreData, memFwd;
	regIdxT memRd;
	wbSelT  memWbSel;
	logic   memRegWrite, memLoad, memStore, memIsHalt;
	logic   wbValid;
	wordT   wbAlu, wbPc4, wbLoad;
	regIdxT wbRd;
	wbSelT  wbWbSel;
	logic   wbRegWrite;

	function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
		case (sel)
			FROMMEM: return memVal;
			FROMWB:  return wbVal;
			default: return regVal;
		endcase
	endfunction

	////////////////////
	// Fetch
	////////////////////
	assign pcPlus4  = pc + 32'd4;
	assign iMemAddr = pc[IMEM_ADDR_W-1:0];
	assign iMemCsN  = halt;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			pc <= RESET_PC;
		else if (!halt) begin
			if (redirect)
				pc <= target;
			else if (!stall)
				pc <= pcPlus4;
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			idValid <= 1'b0;
		else if (!halt) begin
			if (flush)
				idValid <= 1'b0;
			else if (!stall)
				idValid <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!halt && !stall) begin
			idInstr <= iMemData;
			idPc    <= pc;
		end
	end

	////////////////////
	// Decode
	////////////////////
	rvDecoder decoder_i (
		.instr(idInstr), .rs1(decRs1), .rs2(decRs2), .rd(decRd), .imm(decImm),
		.aluOp(decAluOp), .brCond(decBrCond), .wbSel(decWbSel), .useImm(decUseImm),
		.usePcA(decUsePcA), .regWrite(decRegWrite), .memRead(decMemRead),
		.memWrite(decMemWrite), .isJalr(decIsJalr), .isHalt(decIsHalt)
	);

	assign rfRa1 = decRs1;
	assign rfRa2 = decRs2;

	// Writeback in the same cycle lands after the read, take it here
	assign idRs1Val = (rfWe && (rfWa == decRs1)) ? rfWd : rfRd1;
	assign idRs2Val = (rfWe && (rfWa == decRs2)) ? rfWd : rfRd2;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			exValid <= 1'b0;
		else if (!halt)
			exValid <= idValid && !flush && !stall;  // Bubble on stall or flush
	end

	always_ff @(posedge CLK) begin
		if (!halt) begin
			exPc       <= idPc;
			exRs1Val   <= idRs1Val;
			exRs2Val   <= idRs2Val;
			exImm      <= decImm;
			exRs1      <= decRs1;
			exRs2      <= decRs2;
			exRd       <= decRd;
			exAluOp    <= decAluOp;
			exBrCond   <= decBrCond;
			exWbSel    <= decWbSel;
			exUseImm   <= decUseImm;
			exUsePcA   <= decUsePcA;
			exRegWrite <= decRegWrite;
			exMemRead  <= decMemRead;
			exMemWrite <= decMemWrite;
			exIsJalr   <= decIsJalr;
			exIsHalt   <= decIsHalt;
		end
	end

	////////////////////
	// Execute
	////////////////////
	rvHazardUnit hazard_i (
		.exRs1(exRs1), .exRs2(exRs2), .memRd(memRd), .wbRd(wbRd), .exRd(exRd),
		.memRegWrite(memValid && memRegWrite), .wbRegWrite(wbValid && wbRegWrite),
		.exMemRead(exValid && exMemRead), .redirect(redirect),
		.idRs1(decRs1), .idRs2(decRs2),
		.fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
	);

	assign fwdValA = fwdMux(fwdA, exRs1Val, memFwd, rfWd);
	assign fwdValB = fwdMux(fwdB, exRs2Val, memFwd, rfWd);
	assign aluA    = exUsePcA ? exPc : fwdValA;
	assign aluB    = exUseImm ? exImm : fwdValB;

	rvAlu alu_i (
		.aluOp(exAluOp), .brCond(exBrCond), .a(aluA), .b(aluB),
		.result(aluResult), .taken(taken)
	);

	// Branch and JAL add to the PC, JALR to rs1 with bit 0 cleared
	assign targetSum = (exIsJalr ? fwdValA : exPc) + exImm;
	assign target    = {targetSum[31:1], targetSum[0] & ~exIsJalr};
	assign redirect  = exValid && taken;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			memValid <= 1'b0;
		else if (!halt)
			memValid <= exValid;
	end

	always_ff @(posedge CLK) begin
		if (!halt) begin
			memAlu       <= aluResult;
			memPc4       <= exPc + 32'd4;
			memStoreData <= fwdValB;
			memRd        <= exRd;
			memWbSel     <= exWbSel;
			memRegWrite  <= exRegWrite;
			memLoad      <= exMemRead;
			memStore     <= exMemWrite;
			memIsHalt    <= exIsHalt;
		end
	end

	////////////////////
	// Memory
	////////////////////
	assign memFwd    = (memWbSel == PCPLUS4) ? memPc4 : memAlu;  // Loads never forward here
	assign dMemCsN   = !(memValid && (memLoad || memStore)) || halt;
	assign dMemWeN   = !(memValid && memStore) || halt;
	assign dMemAddr  = memAlu[DMEM_ADDR_W+1:2];
	assign dMemWdata = memStoreData;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			wbValid <= 1'b0;
		else if (!halt)
			wbValid <= memValid;
	end

	always_ff @(posedge CLK) begin
		if (!halt) begin
			wbAlu      <= memAlu;
			wbPc4      <= memPc4;
			wbLoad     <= dMemRdata;
			wbRd       <= memRd;
			wbWbSel    <= memWbSel;
			wbRegWrite <= memRegWrite;
		end
	end

	////////////////////
	// Writeback
	////////////////////
	always_comb begin
		case (wbWbSel)
			MEM:     rfWd = wbLoad;
			PCPLUS4: rfWd = wbPc4;
			default: rfWd = wbAlu;
		endcase
	end

	assign rfWe = wbValid && wbRegWrite && !halt;
	assign rfWa = wbRd;

	// Sticky until reset, rises as EBREAK enters MEM/WB
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			halt <= 1'b0;
		else if (memValid && memIsHalt)
			halt <= 1'b1;
	end

	// EBREAK itself is not counted, the count freezes with halt
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			numInst <= '0;
		else if (wbValid && !halt)
			numInst <= numInst + 32'd1;
	end

endmodule

`default_nettype wire

// ==== bench/rvTb.sv ====
`default_nettype none
`timescale 1ns/100ps

module rvTb
	import rvIsaPkg::*;
();

	localparam int   IMEM_ADDR_W = 12;
	localparam int   DMEM_ADDR_W = 10;
	localparam int   IMEM_WORDS  = 1 << (IMEM_ADDR_W - 2);
	localparam int   DMEM_WORDS  = 1 << DMEM_ADDR_W;
	localparam wordT EBREAK_W    = 32'h0010_0073;

	logic                   CLK;
	logic                   rstN;
	logic [IMEM_ADDR_W-1:0] iMemAddr;
	logic                   iMemCsN;
	wordT                   iMemData;
	logic                   dMemCsN;
	logic                   dMemWeN;
	logic [DMEM_ADDR_W-1:0] dMemAddr;
	wordT                   dMemWdata;
	wordT                   dMemRdata;
	regIdxT                 rfRa1;
	regIdxT                 rfRa2;
	wordT                   rfRd1;
	wordT                   rfRd2;
	logic                   rfWe;
	regIdxT                 rfWa;
	wordT                   rfWd;
	logic                   halt;
	logic [31:0]            numInst;

	wordT        iMem [IMEM_WORDS];
	wordT        dMem [DMEM_WORDS];
	wordT        dInit [DMEM_WORDS];  // Data image seen by the reference
	wordT        rf [32];
	int          progLen;
	int          cycleCount = 0;
	int          cycleLimit = 0;
	logic [31:0] refRetire;
	regIdxT      expWrIdx[$];
	wordT        expWrVal[$];
	wordT        expStAddr[$];
	wordT        expStData[$];
	int          wrPos = 0;
	int          stPos = 0;

	rvTop #(
		.IMEM_ADDR_W(IMEM_ADDR_W),
		.DMEM_ADDR_W(DMEM_ADDR_W)
	) dut_i (
		.CLK(CLK), .rstN(rstN), .iMemAddr(iMemAddr), .iMemCsN(iMemCsN), .iMemData(iMemData),
		.dMemCsN(dMemCsN), .dMemWeN(dMemWeN), .dMemAddr(dMemAddr), .dMemWdata(dMemWdata),
		.dMemRdata(dMemRdata), .rfRa1(rfRa1), .rfRa2(rfRa2), .rfRd1(rfRd1), .rfRd2(rfRd2),
		.rfWe(rfWe), .rfWa(rfWa), .rfWd(rfWd), .halt(halt), .numInst(numInst)
	);

	always #2 CLK = ~CLK;

	////////////////////
	// Memory and register-file models
	////////////////////
	assign iMemData  = iMem[iMemAddr[IMEM_ADDR_W-1:2]];
	assign dMemRdata = dMem[dMemAddr];
	assign rfRd1     = (rfRa1 == '0) ? '0 : rf[rfRa1];
	assign rfRd2     = (rfRa2 == '0) ? '0 : rf[rfRa2];

	always @(posedge CLK) begin
		if (!dMemCsN && !dMemWeN)
			dMem[dMemAddr] <= dMemWdata;
		if (rfWe && (rfWa != '0))
			rf[rfWa] <= rfWd;
	end

	task automatic stopOnError(string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	////////////////////
	// Instruction encoders
	////////////////////
	function automatic wordT encR(logic [6:0] f7, regIdxT rs2, regIdxT rs1, logic [2:0] f3,
		regIdxT rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic wordT encI(logic [11:0] imm, regIdxT rs1, logic [2:0] f3, regIdxT rd,
		opcodeT op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic wordT encS(logic [11:0] imm, regIdxT rs2, regIdxT rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // SW only
	endfunction

	function automatic wordT encB(logic [12:0] off, logic [2:0] f3, regIdxT rs1, regIdxT rs2);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic wordT encU(logic [19:0] imm, regIdxT rd, opcodeT op);
		return {imm, rd, op};
	endfunction

	function automatic wordT encJ(logic [20:0] off, regIdxT rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic emit(wordT w);
		iMem[progLen] = w;
		progLen++;
	endtask

	function automatic regIdxT randReg(int lo, int hi);
		wordT r;
		r = $urandom_range(hi, lo);
		return r[4:0];
	endfunction

	task automatic emitRandomAlu();
		int         kind;
		wordT       r;
		logic [2:0] f3;
		logic       alt;
		regIdxT     rd, rs1, rs2;
		kind = $urandom_range(3, 0);
		r    = $urandom;
		f3   = r[2:0];
		alt  = r[3];
		rd   = randReg(1, 15);
		rs1  = randReg(0, 15);
		rs2  = randReg(0, 15);
		r    = $urandom;
		case (kind)
			0: emit(encR((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
			1: begin
				if (f3 == 3'd1 || f3 == 3'd5)  // Shifts keep the upper field clean
					emit(encI({((alt && f3 == 3'd5) ? 7'h20 : 7'h00), r[4:0]},
						rs1, f3, rd, OP_IMM));
				else
					emit(encI(r[11:0], rs1, f3, rd, OP_IMM));
			end
			2: emit(encU(r[19:0], rd, LUI));
			default: emit(encU(r[19:0], rd, AUIPC));
		endcase
	endtask

	task automatic buildProgram();
		int         i;
		int         k;
		logic [2:0] brF3 [6];
		regIdxT     ra, rb;
		brF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		for (i = 0; i < IMEM_WORDS; i++)
			iMem[i] = encI(i[11:0], 5'd0, 3'd0, 5'd0, OP_IMM);  // addi x0 tagged by address
		progLen = 0;
		for (i = 0; i < 40; i++)
			emitRandomAlu();
		// Dependent chain, then loads used right away
		emit(encI(12'h200, 5'd0, 3'd0, 5'd10, OP_IMM));
		emit(encI(12'd3, 5'd1, 3'd0, 5'd5, OP_IMM));
		emit(encR(7'h00, 5'd5, 5'd5, 3'd0, 5'd6));
		emit(encR(7'h20, 5'd5, 5'd6, 3'd0, 5'd7));
		emit(encI(12'd4, 5'd10, 3'd2, 5'd11, LOAD));
		emit(encR(7'h00, 5'd11, 5'd11, 3'd0, 5'd12));
		emit(encI(12'd8, 5'd10, 3'd2, 5'd13, LOAD));
		emit(encS(12'd12, 5'd13, 5'd10));  // Store data is the fresh load
		emit(encI(12'd12, 5'd10, 3'd2, 5'd14, LOAD));
		emit(encI(12'd1, 5'd14, 3'd0, 5'd15, OP_IMM));
		emit(encS(12'd16, 5'd7, 5'd10));
		emit(encS(12'd20, 5'd12, 5'd10));
		emit(encI(12'd16, 5'd10, 3'd2, 5'd16, LOAD));
		emit(encR(7'h00, 5'd16, 5'd3, 3'd4, 5'd17));
		// Six conditions on equal operands, then on random ones
		for (k = 0; k < 2; k++) begin
			ra = (k == 0) ? 5'd1 : 5'd2;
			rb = (k == 0) ? 5'd1 : 5'd3;
			for (i = 0; i < 6; i++) begin
				emit(encB(13'd8, brF3[i], ra, rb));
				emit(encI(12'd1, 5'd20, 3'd0, 5'd20, OP_IMM));  // Shadow slot
				emit(encI(12'd1, 5'd21, 3'd0, 5'd21, OP_IMM));
			end
		end
		emit(encJ(21'd12, 5'd1));
		emit(encI(12'd1, 5'd0, 3'd0, 5'd22, OP_IMM));
		emit(encI(12'd2, 5'd0, 3'd0, 5'd22, OP_IMM));
		emit(encR(7'h00, 5'd0, 5'd1, 3'd0, 5'd23));
		emit(encU(20'd0, 5'd24, AUIPC));
		emit(encI(12'd17, 5'd24, 3'd0, 5'd25, JALR));  // Odd offset loses bit 0
		emit(encI(12'd5, 5'd0, 3'd0, 5'd26, OP_IMM));
		emit(encI(12'd6, 5'd0, 3'd0, 5'd26, OP_IMM));
		emit(encR(7'h00, 5'd0, 5'd25, 3'd0, 5'd26));
		emit(EBREAK_W);
	endtask

	////////////////////
	// Reference interpreter
	////////////////////
	function automatic wordT refAlu(logic [2:0] f3, logic alt, wordT a, wordT b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'b0, $signed(a) < $signed(b)};
			3'd3:    return {31'b0, a < b};
			3'd4:    return a ^ b;
			3'd5:    return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] refRun();
		wordT        regs [32];
		wordT        mem [DMEM_WORDS];
		wordT        pc, w, a, b, res, addr, nextPc, immI;
		logic [2:0]  f3;
		regIdxT      rd;
		logic [31:0] retired;
		logic        writes;
		logic        taken;
		int          i;
		int          steps;
		for (i = 0; i < 32; i++)
			regs[i] = '0;
		for (i = 0; i < DMEM_WORDS; i++)
			mem[i] = dInit[i];
		pc      = '0;
		retired = '0;
		steps   = 0;
		while (steps < 4000) begin
			w = iMem[pc[IMEM_ADDR_W-1:2]];
			if (w == EBREAK_W)
				break;
			f3     = w[14:12];
			rd     = w[11:7];
			a      = regs[w[19:15]];
			b      = regs[w[24:20]];
			immI   = {{20{w[31]}}, w[31:20]};
			nextPc = pc + 32'd4;
			writes = 1'b1;
			res    = '0;
			case (w[6:0])
				7'b0110011: res = refAlu(f3, w[30], a, b);
				7'b0010011: res = refAlu(f3, (f3 == 3'd5) && w[30], a, immI);
				7'b0110111: res = {w[31:12], 12'b0};
				7'b0010111: res = pc + {w[31:12], 12'b0};
				7'b0000011: begin
					addr = a + immI;
					res  = mem[addr[DMEM_ADDR_W+1:2]];
				end
				7'b0100011: begin
					addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
					mem[addr[DMEM_ADDR_W+1:2]] = b;
					expStAddr.push_back(addr);
					expStData.push_back(b);
					writes = 1'b0;
				end
				7'b1100011: begin
					case (f3)
						3'd0:    taken = (a == b);
						3'd1:    taken = (a != b);
						3'd4:    taken = ($signed(a) < $signed(b));
						3'd5:    taken = ($signed(a) >= $signed(b));
						3'd6:    taken = (a < b);
						default: taken = (a >= b);
					endcase
					if (taken)
						nextPc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
					writes = 1'b0;
				end
				7'b1101111: begin
					res    = pc + 32'd4;
					nextPc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				end
				7'b1100111: begin
					res    = pc + 32'd4;
					nextPc = (a + immI) & ~32'd1;
				end
				default: writes = 1'b0;
			endcase
			if (writes && (rd != '0)) begin
				regs[rd] = res;
				expWrIdx.push_back(rd);
				expWrVal.push_back(res);
			end
			retired = retired + 32'd1;
			pc      = nextPc;
			steps++;
		end
		return retired;
	endfunction

	////////////////////
	// Monitor
	////////////////////
	always @(negedge CLK) begin
		if (rstN) begin
			if (rfWe) begin
				assert (wrPos < expWrIdx.size()) else
					stopOnError($sformatf("Register write to x%0d after the expected writes ended",
						rfWa));
				assert (rfWa == expWrIdx[wrPos]) else
					stopOnError($sformatf("Error: rfWa expected %h got %h", expWrIdx[wrPos], rfWa));
				assert (rfWd == expWrVal[wrPos]) else
					stopOnError($sformatf("Error: rfWd expected %h got %h", expWrVal[wrPos], rfWd));
				wrPos++;
			end
			if (!dMemCsN && !dMemWeN) begin
				assert (stPos < expStAddr.size()) else
					stopOnError("A store strobe appeared that the reference does not predict");
				assert (dMemAddr == expStAddr[stPos][DMEM_ADDR_W+1:2]) else
					stopOnError($sformatf("Error: dMemAddr expected %h got %h",
						expStAddr[stPos][DMEM_ADDR_W+1:2], dMemAddr));
				assert (dMemWdata == expStData[stPos]) else
					stopOnError($sformatf("Error: dMemWdata expected %h got %h",
						expStData[stPos], dMemWdata));
				stPos++;
			end
		end
	end

	always @(posedge CLK) begin
		cycleCount = cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout: the core did not halt within %0d cycles", cycleLimit);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	end

	////////////////////
	// Stimulus
	////////////////////
	initial begin
		int i;
		void'($urandom(11));
		CLK  = 1'b0;
		rstN = 1'b0;
		for (i = 0; i < 32; i++)
			rf[i] = '0;
		for (i = 0; i < DMEM_WORDS; i++) begin
			dMem[i]  = $urandom;
			dInit[i] = dMem[i];
		end
		buildProgram();
		refRetire  = refRun();
		cycleLimit = 5 * progLen + 100;
		repeat (5) @(posedge CLK);
		#1 rstN = 1'b1;
		repeat (3) begin  // Nothing can retire yet
			@(negedge CLK);
			assert (rfWe == 1'b0) else
				stopOnError($sformatf("Error: rfWe expected 0 got %h", rfWe));
			assert (dMemCsN == 1'b1) else
				stopOnError($sformatf("Error: dMemCsN expected 1 got %h", dMemCsN));
			assert (dMemWeN == 1'b1) else
				stopOnError($sformatf("Error: dMemWeN expected 1 got %h", dMemWeN));
			assert (iMemCsN == 1'b0) else
				stopOnError($sformatf("Error: iMemCsN expected 0 got %h", iMemCsN));
			assert (halt == 1'b0) else
				stopOnError($sformatf("Error: halt expected 0 got %h", halt));
			assert (numInst == '0) else
				stopOnError($sformatf("Error: numInst expected 0 got %h", numInst));
		end
		wait (halt === 1'b1);
		@(negedge CLK);
		assert (numInst == refRetire) else
			stopOnError($sformatf("Error: numInst expected %h got %h", refRetire, numInst));
		repeat (10) begin  // Halted core must stay quiet
			@(negedge CLK);
			assert (iMemCsN == 1'b1) else
				stopOnError($sformatf("Error: iMemCsN expected 1 got %h", iMemCsN));
			assert (dMemCsN == 1'b1) else
				stopOnError($sformatf("Error: dMemCsN expected 1 got %h", dMemCsN));
			assert (rfWe == 1'b0) else
				stopOnError($sformatf("Error: rfWe expected 0 got %h", rfWe));
			assert (halt == 1'b1) else
				stopOnError($sformatf("Error: halt expected 1 got %h", halt));
			assert (numInst == refRetire) else
				stopOnError($sformatf("Error: numInst expected %h got %h", refRetire, numInst));
		end
		if (wrPos == expWrIdx.size() && stPos == expStAddr.size()) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("Saw %0d of %0d register writes and %0d of %0d stores",
				wrPos, expWrIdx.size(), stPos, expStAddr.size());
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/rvIsaPkg.sv
rtl/rvPipePkg.sv
rtl/rvDecoder.sv
rtl/rvAlu.sv
rtl/rvHazardUnit.sv
rtl/rvTop.sv
bench/rvTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rvTb
RTL_TOP   ?= rvTop
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
